// File: hw/alu_pkg.sv
/* Common widths, opcode and forward-select encodings and payload types for the
   integer execution lane. Imported by wildcard into every lane module. */

`default_nettype none

package alu_pkg;

  localparam int DATA_W = 64;
  localparam int NUM_BUSES = 4;

  // Forward-select code of result bus i is its base plus i
  localparam int FWD_LIVE_BASE = 1;
  localparam int FWD_DLY_BASE = 5;

  // Function select of the adder/logic unit
  localparam logic [1:0] LOGIC_NONE = 2'd0;
  localparam logic [1:0] LOGIC_AND = 2'd1;
  localparam logic [1:0] LOGIC_OR = 2'd2;
  localparam logic [1:0] LOGIC_XOR = 2'd3;

  typedef logic [DATA_W-1:0] data_t;

  // 0 takes the supplied operand, as does any unlisted code
  typedef logic [3:0] fwd_src_t;

  typedef struct packed {
    logic c;
    logic o;
    logic s;
    logic z;
    logic p;
    logic a;
  } flags_t;

  typedef enum logic [4:0] {
    OP_ADD64 = 5'd0,
    OP_ADD32 = 5'd1,
    OP_SUB64 = 5'd2,
    OP_SUB32 = 5'd3,
    OP_ADC64 = 5'd4,
    OP_CMP64 = 5'd5,
    OP_CMP32 = 5'd6,
    OP_AND64 = 5'd7,
    OP_OR64 = 5'd8,
    OP_XOR64 = 5'd9,
    OP_SHL64 = 5'd10,
    OP_SHL32 = 5'd11,
    OP_SHR64 = 5'd12,
    OP_SHR32 = 5'd13,
    OP_SAR64 = 5'd14,
    OP_SAR32 = 5'd15
  } op_t;

  typedef enum logic {
    UNIT_ADD = 1'b0,
    UNIT_SHIFT = 1'b1
  } unit_sel_t;

endpackage

`default_nettype wire

// File: hw/operand_forward.sv
/* Operand forwarding from the result buses. The operand comes from the supplied
   value, a live bus, or a bus as it was one cycle earlier. Used for both data
   and flags operands through the payload type parameter. */

`timescale 1ns/100ps
`default_nettype none

module operand_forward
  import alu_pkg::*;
#(
  parameter type payload_t = data_t
) (
  input  wire      clk,
  input  wire      rst_n,
  input  fwd_src_t src,
  input  payload_t operand,
  input  payload_t bus [NUM_BUSES],
  output payload_t value
);

  // Copy of every bus from the previous cycle
  payload_t bus_q [NUM_BUSES];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < NUM_BUSES; i++) begin
        bus_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NUM_BUSES; i++) begin
        bus_q[i] <= bus[i];
      end
    end
  end

  always_comb begin
    value = operand;
    for (int i = 0; i < NUM_BUSES; i++) begin
      if (src == fwd_src_t'(FWD_LIVE_BASE + i)) begin
        value = bus[i];
      end
      if (src == fwd_src_t'(FWD_DLY_BASE + i)) begin
        value = bus_q[i];
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/alu_issue.sv
/* Issue stage of the lane. Decodes the opcode into unit controls and captures
   them with the resolved operands on the issue strobe. Outputs feed both
   execution units and the merge stage for one execute cycle. */

`timescale 1ns/100ps
`default_nettype none

module alu_issue
  import alu_pkg::*;
(
  input  wire        clk,
  input  wire        rst_n,
  input  wire        en,
  input  op_t        op,
  input  data_t      a,
  input  data_t      b,
  input  flags_t     s,
  output logic       valid,
  output data_t      opr_a,
  output data_t      opr_b,
  output flags_t     opr_s,
  output logic       is_32,
  output logic       is_sub,
  output logic       use_carry,
  output logic [1:0] logic_fn,
  output logic       shift_left,
  output logic       shift_arith,
  output unit_sel_t  unit,
  output logic       write_back
);

  logic       dec_is_32;
  logic       dec_is_sub;
  logic       dec_use_carry;
  logic [1:0] dec_logic_fn;
  logic       dec_shift_left;
  logic       dec_shift_arith;
  unit_sel_t  dec_unit;
  logic       dec_write_back;

  assign dec_is_32 = op inside {OP_ADD32, OP_SUB32, OP_CMP32, OP_SHL32, OP_SHR32, OP_SAR32};
  // Compares run through the subtractor
  assign dec_is_sub = op inside {OP_SUB64, OP_SUB32, OP_CMP64, OP_CMP32};
  assign dec_use_carry = (op == OP_ADC64);
  assign dec_shift_left = op inside {OP_SHL64, OP_SHL32};
  assign dec_shift_arith = op inside {OP_SAR64, OP_SAR32};
  assign dec_write_back = !(op inside {OP_CMP64, OP_CMP32});

  assign dec_unit = (op inside {OP_SHL64, OP_SHL32, OP_SHR64, OP_SHR32, OP_SAR64, OP_SAR32})
                    ? UNIT_SHIFT : UNIT_ADD;

  always_comb begin
    case (op)
      OP_AND64: dec_logic_fn = LOGIC_AND;
      OP_OR64:  dec_logic_fn = LOGIC_OR;
      OP_XOR64: dec_logic_fn = LOGIC_XOR;
      default:  dec_logic_fn = LOGIC_NONE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid       <= 1'b0;
      is_32       <= 1'b0;
      is_sub      <= 1'b0;
      use_carry   <= 1'b0;
      logic_fn    <= LOGIC_NONE;
      shift_left  <= 1'b0;
      shift_arith <= 1'b0;
      unit        <= UNIT_ADD;
      write_back  <= 1'b0;
    end else begin
      valid <= en;
      if (en) begin
        is_32       <= dec_is_32;
        is_sub      <= dec_is_sub;
        use_carry   <= dec_use_carry;
        logic_fn    <= dec_logic_fn;
        shift_left  <= dec_shift_left;
        shift_arith <= dec_shift_arith;
        unit        <= dec_unit;
        write_back  <= dec_write_back;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (en) begin
      opr_a <= a;
      opr_b <= b;
      opr_s <= s;
    end
  end

endmodule

`default_nettype wire

// File: hw/add_logic_unit.sv
/* Combinational adder and logic unit of the lane. Handles add, subtract,
   add with carry-in, compare and the bitwise functions, with flags taken
   at bit 31 or bit 63. */

`timescale 1ns/100ps
`default_nettype none

module add_logic_unit
  import alu_pkg::*;
(
  input  data_t      opr_a,
  input  data_t      opr_b,
  input  flags_t     opr_s,
  input  wire        is_32,
  input  wire        is_sub,
  input  wire        use_carry,
  input  wire  [1:0] logic_fn,
  output data_t      sum,
  output flags_t     sum_flags
);

  data_t           b_op;
  logic            cin;
  logic [DATA_W:0] total;
  data_t           raw;
  logic            carry_raw;
  logic            half_raw;
  logic            msb_a;
  logic            msb_b;
  logic            msb_r;

  // Subtract is a + ~b + 1
  assign b_op = is_sub ? ~opr_b : opr_b;
  assign cin = is_sub | (use_carry & opr_s.c);
  assign total = {1'b0, opr_a} + {1'b0, b_op} + {{DATA_W{1'b0}}, cin};

  // Carry out of bit 31 recovered from the bit 32 sum
  assign carry_raw = is_32 ? (opr_a[32] ^ b_op[32] ^ total[32]) : total[DATA_W];
  assign half_raw = opr_a[4] ^ b_op[4] ^ total[4];

  always_comb begin
    case (logic_fn)
      LOGIC_AND: raw = opr_a & opr_b;
      LOGIC_OR:  raw = opr_a | opr_b;
      LOGIC_XOR: raw = opr_a ^ opr_b;
      LOGIC_NONE: raw = total[DATA_W-1:0];
    endcase
  end

  assign sum = is_32 ? {32'b0, raw[31:0]} : raw;

  assign msb_a = is_32 ? opr_a[31] : opr_a[DATA_W-1];
  assign msb_b = is_32 ? b_op[31] : b_op[DATA_W-1];
  assign msb_r = is_32 ? sum[31] : sum[DATA_W-1];

  always_comb begin
    sum_flags = '0;
    if (logic_fn == LOGIC_NONE) begin
      // Carry and half carry become borrows on subtract
      sum_flags.c = carry_raw ^ is_sub;
      sum_flags.o = (msb_a == msb_b) && (msb_r != msb_a);
      sum_flags.a = half_raw ^ is_sub;
    end
    sum_flags.s = msb_r;
    sum_flags.z = ~|sum;
    sum_flags.p = ~^sum[7:0];
  end

endmodule

`default_nettype wire

// File: hw/shift_unit.sv
/* Combinational shifter of the lane. Left, logical right and arithmetic
   right shifts in 32-bit and 64-bit forms with masked counts. */

`timescale 1ns/100ps
`default_nettype none

module shift_unit
  import alu_pkg::*;
(
  input  data_t  opr_a,
  input  data_t  opr_b,
  input  wire    is_32,
  input  wire    shift_left,
  input  wire    shift_arith,
  output data_t  shifted,
  output flags_t shift_flags
);

  logic [5:0] count;
  data_t      src;
  data_t      raw;

  assign count = is_32 ? {1'b0, opr_b[4:0]} : opr_b[5:0];

  // 32-bit sources are widened so one 64-bit shifter serves both widths
  always_comb begin
    if (!is_32) begin
      src = opr_a;
    end else if (shift_arith) begin
      src = {{32{opr_a[31]}}, opr_a[31:0]};
    end else begin
      src = {32'b0, opr_a[31:0]};
    end
  end

  always_comb begin
    if (shift_left) begin
      raw = src << count;
    end else if (shift_arith) begin
      raw = data_t'($signed(src) >>> count);
    end else begin
      raw = src >> count;
    end
  end

  assign shifted = is_32 ? {32'b0, raw[31:0]} : raw;

  always_comb begin
    shift_flags = '0;
    shift_flags.s = is_32 ? shifted[31] : shifted[DATA_W-1];
    shift_flags.z = ~|shifted;
    shift_flags.p = ~^shifted[7:0];
  end

endmodule

`default_nettype wire

// File: hw/result_merge.sv
/* Merge stage of the lane. Picks the active unit's result and flags and
   registers them with the write-enable and done strobes. */

`timescale 1ns/100ps
`default_nettype none

module result_merge
  import alu_pkg::*;
(
  input  wire       clk,
  input  wire       rst_n,
  input  wire       valid,
  input  unit_sel_t unit,
  input  wire       write_back,
  input  data_t     sum,
  input  data_t     shifted,
  input  flags_t    sum_flags,
  input  flags_t    shift_flags,
  output data_t     res,
  output flags_t    flags,
  output logic      res_we,
  output logic      done
);

  data_t  pick_res;
  flags_t pick_flags;

  assign pick_res = (unit == UNIT_SHIFT) ? shifted : sum;
  assign pick_flags = (unit == UNIT_SHIFT) ? shift_flags : sum_flags;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flags  <= '0;
      res_we <= 1'b0;
      done   <= 1'b0;
    end else begin
      res_we <= valid & write_back;
      done   <= valid;
      // Flags hold their last value between ops
      if (valid) begin
        flags <= pick_flags;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (valid) begin
      res <= pick_res;
    end
  end

endmodule

`default_nettype wire

// File: hw/alu_lane.sv
/* Top level of the integer execution lane. Operands are resolved from the
   result buses in the issue cycle, executed one cycle later and the result
   appears with done two cycles after the issue strobe. */

`timescale 1ns/100ps
`default_nettype none

module alu_lane
  import alu_pkg::*;
(
  input  wire      clk,
  input  wire      rst_n,
  input  wire      en,
  input  op_t      op,
  input  data_t    a,
  input  data_t    b,
  input  flags_t   s,
  input  fwd_src_t a_src,
  input  fwd_src_t b_src,
  input  fwd_src_t s_src,
  input  data_t    data_bus [NUM_BUSES],
  input  flags_t   flag_bus [NUM_BUSES],
  output data_t    res,
  output logic     res_we,
  output flags_t   flags,
  output logic     done
);

  data_t      fwd_a;
  data_t      fwd_b;
  flags_t     fwd_s;

  logic       valid;
  data_t      opr_a;
  data_t      opr_b;
  flags_t     opr_s;
  logic       is_32;
  logic       is_sub;
  logic       use_carry;
  logic [1:0] logic_fn;
  logic       shift_left;
  logic       shift_arith;
  unit_sel_t  unit;
  logic       write_back;

  data_t      sum;
  flags_t     sum_flags;
  data_t      shifted;
  flags_t     shift_flags;

  operand_forward #(.payload_t(data_t)) a_fwd_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .src     (a_src),
    .operand (a),
    .bus     (data_bus),
    .value   (fwd_a)
  );

  operand_forward #(.payload_t(data_t)) b_fwd_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .src     (b_src),
    .operand (b),
    .bus     (data_bus),
    .value   (fwd_b)
  );

  operand_forward #(.payload_t(flags_t)) s_fwd_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .src     (s_src),
    .operand (s),
    .bus     (flag_bus),
    .value   (fwd_s)
  );

  alu_issue issue_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .en          (en),
    .op          (op),
    .a           (fwd_a),
    .b           (fwd_b),
    .s           (fwd_s),
    .valid       (valid),
    .opr_a       (opr_a),
    .opr_b       (opr_b),
    .opr_s       (opr_s),
    .is_32       (is_32),
    .is_sub      (is_sub),
    .use_carry   (use_carry),
    .logic_fn    (logic_fn),
    .shift_left  (shift_left),
    .shift_arith (shift_arith),
    .unit        (unit),
    .write_back  (write_back)
  );

  add_logic_unit add_i (
    .opr_a     (opr_a),
    .opr_b     (opr_b),
    .opr_s     (opr_s),
    .is_32     (is_32),
    .is_sub    (is_sub),
    .use_carry (use_carry),
    .logic_fn  (logic_fn),
    .sum       (sum),
    .sum_flags (sum_flags)
  );

  shift_unit shift_i (
    .opr_a       (opr_a),
    .opr_b       (opr_b),
    .is_32       (is_32),
    .shift_left  (shift_left),
    .shift_arith (shift_arith),
    .shifted     (shifted),
    .shift_flags (shift_flags)
  );

  result_merge merge_i (
    .clk         (clk),
    .rst_n       (rst_n),
    .valid       (valid),
    .unit        (unit),
    .write_back  (write_back),
    .sum         (sum),
    .shifted     (shifted),
    .sum_flags   (sum_flags),
    .shift_flags (shift_flags),
    .res         (res),
    .flags       (flags),
    .res_we      (res_we),
    .done        (done)
  );

endmodule

`default_nettype wire

// File: testbench/alu_lane_asserts.sv
/* Concurrent checks on the lane pipeline timing. Bound to alu_lane from the
   testbench, it watches the issue strobe and the done and write-enable outputs. */

`timescale 1ns/100ps
`default_nettype none

module alu_lane_asserts (
  input wire clk,
  input wire rst_n,
  input wire en,
  input wire done,
  input wire res_we
);

  int fail_count = 0;

  done_known: assert property (
    @(posedge clk) disable iff (!rst_n) !$isunknown(done)
  ) else begin
    $error("done is unknown after reset");
    fail_count = fail_count + 1;
  end

  // Fixed two-cycle latency from issue to done
  done_latency: assert property (
    @(posedge clk) disable iff (!rst_n) done == $past(en, 2)
  ) else begin
    $error("done does not follow the issue strobe by two cycles");
    fail_count = fail_count + 1;
  end

  we_with_done: assert property (
    @(posedge clk) disable iff (!rst_n) res_we |-> done
  ) else begin
    $error("res_we raised without done");
    fail_count = fail_count + 1;
  end

endmodule

`default_nettype wire

// File: testbench/alu_lane_tb.sv
/* Testbench for the integer execution lane. Applies a table of directed
   vectors, then a random phase checked against a reference model, one op per
   cycle, and checks every result two cycles after its issue. */

`timescale 1ns/100ps
`default_nettype none

module alu_lane_tb
  import alu_pkg::*;
();

  localparam int CLK_PERIOD = 4;
  localparam int N_TAB = 22;
  localparam int N_RAND = 200;

  typedef struct packed {
    op_t        op;
    data_t      a;
    data_t      b;
    flags_t     s;
    fwd_src_t   a_src;
    fwd_src_t   b_src;
    fwd_src_t   s_src;
    data_t      bus_d;
    logic [3:0] bus_fc;
    data_t      res;
    flags_t     flags;
    logic       we;
  } vec_t;

  logic     clk = 1'b0;
  logic     rst_n = 1'b0;
  logic     en;
  op_t      op;
  data_t    a;
  data_t    b;
  flags_t   s;
  fwd_src_t a_src;
  fwd_src_t b_src;
  fwd_src_t s_src;
  data_t    data_bus [NUM_BUSES];
  flags_t   flag_bus [NUM_BUSES];
  data_t    res;
  logic     res_we;
  flags_t   flags;
  logic     done;

  // Bus values of the previous cycle as the DUT's delayed copies hold them
  data_t    dbus_old [NUM_BUSES];
  flags_t   fbus_old [NUM_BUSES];
  // Expected results in flight with slot 1 due now
  vec_t     pipe [2];
  logic     pipe_v [2];
  logic [31:0] seed = 32'hf885_bdf1;

  // Columns are op, a, b, s, a_src, b_src, s_src, bus base, bus carry bits,
  // expected res, expected flags {c,o,s,z,p,a} and expected res_we.
  // Bus i carries bus base + i and flag bus i carries bit i of the carry mask as c
  vec_t vectors [N_TAB] = '{
    '{OP_ADD64, 64'h7fff_ffff_ffff_ffff, 64'h1, 6'b0, 4'd0, 4'd0, 4'd0,
      64'h0, 4'h0, 64'h8000_0000_0000_0000, 6'b011011, 1'b1},
    '{OP_ADD64, 64'hffff_ffff_ffff_ffff, 64'h1, 6'b0, 4'd0, 4'd0, 4'd0,
      64'h0, 4'h0, 64'h0, 6'b100111, 1'b1},
    '{OP_ADD32, 64'hdead_beef_ffff_fff0, 64'h10, 6'b0, 4'd0, 4'd0, 4'd0,
      64'h0, 4'h0, 64'h0, 6'b100110, 1'b1},
    '{OP_SUB64, 64'h0, 64'h1, 6'b0, 4'd0, 4'd0, 4'd0,
      64'h0, 4'h0, 64'hffff_ffff_ffff_ffff, 6'b101011, 1'b1},
    '{OP_SUB32, 64'h8000_0000, 64'h1, 6'b0, 4'd0, 4'd0, 4'd0,
      64'h0, 4'h0, 64'h7fff_ffff, 6'b010011, 1'b1},
    '{OP_CMP64, 64'h5, 64'h5, 6'b0, 4'd0, 4'd0, 4'd0,
      64'h0, 4'h0, 64'h0, 6'b000110, 1'b0},
    '{OP_CMP32, 64'hffff_ffff_0000_0003, 64'h7, 6'b0, 4'd0, 4'd0, 4'd0,
      64'h0, 4'h0, 64'h0, 6'b101011, 1'b0},
    '{OP_AND64, 64'hf0f0_f0f0_f0f0_f0f0, 64'h0ff0_0ff0_0ff0_0ff0, 6'b0, 4'd0, 4'd0, 4'd0,
      64'h0, 4'h0, 64'h00f0_00f0_00f0_00f0, 6'b000010, 1'b1},
    '{OP_OR64, 64'h8000_0000_0000_0000, 64'h1, 6'b0, 4'd0, 4'd0, 4'd0,
      64'h0, 4'h0, 64'h8000_0000_0000_0001, 6'b001000, 1'b1},
    '{OP_XOR64, 64'h1234_5678_9abc_def0, 64'h1234_5678_9abc_def0, 6'b0, 4'd0, 4'd0, 4'd0,
      64'h0, 4'h0, 64'h0, 6'b000110, 1'b1},
    '{OP_SHL64, 64'h1, 64'h43, 6'b0, 4'd0, 4'd0, 4'd0,
      64'h0, 4'h0, 64'h8, 6'b000000, 1'b1},
    '{OP_SHL32, 64'hffff_ffff_8000_0001, 64'h21, 6'b0, 4'd0, 4'd0, 4'd0,
      64'h0, 4'h0, 64'h2, 6'b000000, 1'b1},
    '{OP_SHR32, 64'hffff_ffff_8000_0000, 64'h4, 6'b0, 4'd0, 4'd0, 4'd0,
      64'h0, 4'h0, 64'h0800_0000, 6'b000010, 1'b1},
    '{OP_SAR64, 64'h8000_0000_0000_0000, 64'h3f, 6'b0, 4'd0, 4'd0, 4'd0,
      64'h0, 4'h0, 64'hffff_ffff_ffff_ffff, 6'b001010, 1'b1},
    '{OP_SAR32, 64'h8000_0010, 64'h4, 6'b0, 4'd0, 4'd0, 4'd0,
      64'h0, 4'h0, 64'hf800_0001, 6'b001000, 1'b1},
    '{OP_SHR64, 64'h8000_0000_0000_0000, 64'h40, 6'b0, 4'd0, 4'd0, 4'd0,
      64'h0, 4'h0, 64'h8000_0000_0000_0000, 6'b001010, 1'b1},
    // Forwarding rows where the delayed codes see the previous row's buses
    '{OP_ADD64, 64'hdead, 64'h10, 6'b0, 4'd1, 4'd0, 4'd0,
      64'h1000, 4'h0, 64'h1010, 6'b000000, 1'b1},
    '{OP_ADD64, 64'h1, 64'h1, 6'b0, 4'd7, 4'd4, 4'd0,
      64'h2000, 4'h0, 64'h3005, 6'b000010, 1'b1},
    '{OP_ADC64, 64'h100, 64'h200, 6'b0, 4'd0, 4'd0, 4'd2,
      64'h3000, 4'b0010, 64'h301, 6'b000000, 1'b1},
    '{OP_ADC64, 64'hffff_ffff_ffff_ffff, 64'h0, 6'b0, 4'd0, 4'd0, 4'd6,
      64'h4000, 4'b0000, 64'h0, 6'b100111, 1'b1},
    '{OP_SUB64, 64'h4000, 64'h1234, 6'b0, 4'd0, 4'd5, 4'd0,
      64'h5000, 4'h0, 64'h0, 6'b000110, 1'b1},
    '{OP_ADD64, 64'h2, 64'h3, 6'b0, 4'd12, 4'd15, 4'd0,
      64'h6000, 4'h0, 64'h5, 6'b000010, 1'b1}
  };

  alu_lane alu_lane_i (.*);

  bind alu_lane alu_lane_asserts asserts_i (
    .clk(clk), .rst_n(rst_n), .en(en), .done(done), .res_we(res_we)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("ERR %s: got %h, expected %h", name, got, exp);
      $display("Done: errors found");
      $fatal(1, "value mismatch");
    end
  endtask

  function automatic data_t resolve_data(input fwd_src_t src, input data_t supplied);
    if (src >= 4'd1 && src <= 4'd4) return data_bus[2'(src - 4'd1)];
    if (src >= 4'd5 && src <= 4'd8) return dbus_old[2'(src - 4'd5)];
    return supplied;
  endfunction

  function automatic flags_t resolve_flags(input fwd_src_t src, input flags_t supplied);
    if (src >= 4'd1 && src <= 4'd4) return flag_bus[2'(src - 4'd1)];
    if (src >= 4'd5 && src <= 4'd8) return fbus_old[2'(src - 4'd5)];
    return supplied;
  endfunction

  // Reference model of the lane arithmetic
  task automatic model_alu(input op_t mop, input data_t x, input data_t y, input flags_t fs,
                           output data_t r, output flags_t f);
    logic               w32;
    logic               cin;
    logic               msb_x;
    logic               msb_y;
    logic               msb_r;
    logic [64:0]        wide;
    logic [4:0]         nib;
    logic [5:0]         cnt;
    logic signed [31:0] lo_s;
    logic signed [63:0] full_s;
    data_t              xs;
    data_t              ys;
    w32 = mop inside {OP_ADD32, OP_SUB32, OP_CMP32, OP_SHL32, OP_SHR32, OP_SAR32};
    xs = w32 ? {32'b0, x[31:0]} : x;
    ys = w32 ? {32'b0, y[31:0]} : y;
    cnt = w32 ? {1'b0, y[4:0]} : y[5:0];
    lo_s = x[31:0];
    full_s = x;
    cin = (mop == OP_ADC64) && fs.c;
    f = '0;
    case (mop)
      OP_ADD64, OP_ADD32, OP_ADC64: begin
        wide = {1'b0, xs} + {1'b0, ys} + {64'b0, cin};
        nib = {1'b0, xs[3:0]} + {1'b0, ys[3:0]} + {4'b0, cin};
        r = wide[63:0];
        f.c = w32 ? wide[32] : wide[64];
        f.a = nib[4];
      end
      OP_SUB64, OP_SUB32, OP_CMP64, OP_CMP32: begin
        r = xs - ys;
        f.c = xs < ys;
        f.a = xs[3:0] < ys[3:0];
      end
      OP_AND64: r = x & y;
      OP_OR64:  r = x | y;
      OP_XOR64: r = x ^ y;
      OP_SHL64, OP_SHL32: r = xs << cnt;
      OP_SHR64, OP_SHR32: r = xs >> cnt;
      default:  r = w32 ? {32'b0, lo_s >>> cnt} : data_t'(full_s >>> cnt);
    endcase
    if (w32) begin
      r = {32'b0, r[31:0]};
    end
    msb_x = w32 ? x[31] : x[63];
    msb_y = w32 ? y[31] : y[63];
    msb_r = w32 ? r[31] : r[63];
    if (mop inside {OP_ADD64, OP_ADD32, OP_ADC64}) begin
      f.o = (msb_x == msb_y) && (msb_r != msb_x);
    end
    if (mop inside {OP_SUB64, OP_SUB32, OP_CMP64, OP_CMP32}) begin
      f.o = (msb_x != msb_y) && (msb_r != msb_x);
    end
    f.s = msb_r;
    f.z = (r == '0);
    f.p = ~^r[7:0];
  endtask

  task automatic check_output(input logic due, input vec_t e);
    if (due) begin
      check_value("done", 64'(done), 64'd1);
      check_value("res_we", 64'(res_we), 64'(e.we));
      check_value("flags", 64'(flags), 64'(e.flags));
      // Compare results are don't-care
      if (e.we) begin
        check_value("res", res, e.res);
      end
    end else begin
      check_value("done", 64'(done), 64'd0);
      check_value("res_we", 64'(res_we), 64'd0);
    end
  endtask

  // Checks the op issued two cycles ago and drives the next one
  task automatic run_cycle(input logic issue, input logic use_model, input vec_t v);
    vec_t   e;
    data_t  xa;
    data_t  xb;
    flags_t xf;
    data_t  mres;
    flags_t mflags;
    @(posedge clk);
    #1;
    check_output(pipe_v[1], pipe[1]);
    pipe[1] = pipe[0];
    pipe_v[1] = pipe_v[0];
    for (int i = 0; i < NUM_BUSES; i++) begin
      dbus_old[i] = data_bus[i];
      fbus_old[i] = flag_bus[i];
      data_bus[i] = v.bus_d + data_t'(i);
      flag_bus[i] = '0;
      flag_bus[i].c = v.bus_fc[i];
    end
    en = issue;
    op = v.op;
    a = v.a;
    b = v.b;
    s = v.s;
    a_src = v.a_src;
    b_src = v.b_src;
    s_src = v.s_src;
    e = v;
    if (use_model) begin
      xa = resolve_data(v.a_src, v.a);
      xb = resolve_data(v.b_src, v.b);
      xf = resolve_flags(v.s_src, v.s);
      model_alu(v.op, xa, xb, xf, mres, mflags);
      e.res = mres;
      e.flags = mflags;
      e.we = !(v.op inside {OP_CMP64, OP_CMP32});
    end
    pipe[0] = e;
    pipe_v[0] = issue;
  endtask

  initial begin
    #((N_TAB + N_RAND + 20) * CLK_PERIOD);
    $display("Timeout: the tests did not complete within the expected time");
    $display("Done: errors found");
    $fatal(1, "watchdog expired");
  end

  initial begin
    vec_t        v;
    logic [31:0] r;
    logic [31:0] r2;
    logic        issue;
    en = 1'b0;
    op = OP_ADD64;
    a = '0;
    b = '0;
    s = '0;
    a_src = '0;
    b_src = '0;
    s_src = '0;
    for (int i = 0; i < NUM_BUSES; i++) begin
      data_bus[i] = '0;
      flag_bus[i] = '0;
      dbus_old[i] = '0;
      fbus_old[i] = '0;
    end
    pipe_v[0] = 1'b0;
    pipe_v[1] = 1'b0;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check_value("done", 64'(done), 64'd0);
    check_value("res_we", 64'(res_we), 64'd0);
    check_value("flags", 64'(flags), 64'd0);

    for (int n = 0; n < N_TAB; n++) begin
      run_cycle(1'b1, 1'b0, vectors[n]);
    end

    // Random ops with an occasional idle cycle
    v = vectors[0];
    for (int n = 0; n < N_RAND; n++) begin
      r = lcg_next();
      r2 = lcg_next();
      v.op = op_t'({1'b0, r[31:28]});
      v.a_src = r[27:24];
      v.b_src = r[23:20];
      v.s_src = r[19:16];
      v.bus_fc = r2[31:28];
      v.s = flags_t'(r2[27:22]);
      issue = (r2[21:19] != 3'd0);
      v.a = {lcg_next(), lcg_next()};
      v.b = {lcg_next(), lcg_next()};
      v.bus_d = {lcg_next(), lcg_next()};
      run_cycle(issue, 1'b1, v);
    end

    // Drain the ops still in flight
    run_cycle(1'b0, 1'b0, v);
    run_cycle(1'b0, 1'b0, v);
    @(posedge clk);
    #1;
    check_output(pipe_v[1], pipe[1]);
    if (alu_lane_i.asserts_i.fail_count != 0) begin
      $display("Pipeline timing assertions failed %0d times",
               alu_lane_i.asserts_i.fail_count);
      $display("Done: errors found");
      $fatal(1, "assertion failures");
    end else begin
      $display("Done: no errors");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: project.f
hw/alu_pkg.sv
hw/operand_forward.sv
hw/alu_issue.sv
hw/add_logic_unit.sv
hw/shift_unit.sv
hw/result_merge.sv
hw/alu_lane.sv
testbench/alu_lane_asserts.sv
testbench/alu_lane_tb.sv

// File: Makefile
# Verilator build and run of the lane testbench

sim:
	verilator --binary --timing --assert -f project.f --top-module alu_lane_tb -Mdir obj_dir
	./obj_dir/Valu_lane_tb | tee sim.log
	grep -q "^Done: no errors$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
